// File: include/frontend_consts.svh
`ifndef FRONTEND_CONSTS_SVH
`define FRONTEND_CONSTS_SVH

// register files
`define PHYS_REGS      8
`define PR_ADDR_W      3
`define ARCH_REGS      4
`define AR_ADDR_W      2

// instruction fields
`define MACRO_OP_W     8
`define OPC_W          3
`define UOP_W          9
`define RENAMED_OP_SZ  12

// buffers
`define ALU_BUF_ELEMS  4
`define ALU_BUF_IDX_W  2

`endif

// File: logic/frontend_pkg.sv
`include "frontend_consts.svh"

package frontend_pkg;

    typedef enum logic [`OPC_W-1:0] {
        M_ADD    = 3'd0,
        M_SUB    = 3'd1,
        M_AND    = 3'd2,
        M_LOAD   = 3'd3,
        M_STORE  = 3'd4,
        M_LDADD  = 3'd5,
        M_BRANCH = 3'd6,
        M_HALT   = 3'd7
    } macro_op_e;

    // code 5 is left free in the micro-op space.
    typedef enum logic [`OPC_W-1:0] {
        U_ADD    = 3'd0,
        U_SUB    = 3'd1,
        U_AND    = 3'd2,
        U_LOAD   = 3'd3,
        U_STORE  = 3'd4,
        U_BRANCH = 3'd6,
        U_HALT   = 3'd7
    } uop_op_e;

    typedef enum logic [1:0] {CLS_ALU, CLS_MEM, CLS_TERM} uop_class_e;

    typedef enum logic {F_FIRST, F_SECOND} fetch_state_e;

endpackage

// File: logic/uop_fetch.sv
`include "frontend_consts.svh"

module uop_fetch (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fetch,
    input  logic [`MACRO_OP_W-1:0] macroop_in,
    input  logic                   microops_ready,
    output logic [`UOP_W-1:0]      microop,
    output logic                   microop_valid,
    output logic                   instr_ready
);
    import frontend_pkg::*;

    logic [`MACRO_OP_W-1:0] mop;
    logic                   full;
    fetch_state_e           state;
    macro_op_e              m_op;
    logic [`AR_ADDR_W-1:0]  m_dst;
    logic [`AR_ADDR_W-1:0]  m_src;
    logic                   xfer;
    logic                   last;

    assign m_op  = macro_op_e'(mop[7:5]);
    assign m_dst = mop[4:3];
    assign m_src = mop[2:1]; // bit 0 carries nothing.

    assign xfer = full & microops_ready;
    assign last = (state == F_SECOND) | (m_op != M_LDADD);

    assign microop_valid = full;
    assign instr_ready   = ~full | (xfer & last);

    always_comb begin
        unique case (m_op)
            M_ADD:    microop = {U_ADD, m_dst, m_dst, m_src};
            M_SUB:    microop = {U_SUB, m_dst, m_dst, m_src};
            M_AND:    microop = {U_AND, m_dst, m_dst, m_src};
            M_LOAD:   microop = {U_LOAD, m_dst, m_src, m_src};
            M_STORE:  microop = {U_STORE, 2'd0, m_dst, m_src}; // no destination write.
            M_LDADD:  microop = (state == F_FIRST) ? {U_LOAD, m_dst, m_src, m_src}
                                                   : {U_ADD, m_dst, m_dst, m_dst};
            M_BRANCH: microop = {U_BRANCH, 2'd0, m_src, m_src};
            default:  microop = {U_HALT, 2'd0, m_src, m_src};
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            full  <= 1'b0;
            state <= F_FIRST;
        end else if (fetch) begin
            full  <= 1'b1; // a new macro-op may replace the one finishing now.
            state <= F_FIRST;
        end else if (xfer) begin
            if (last) begin
                full <= 1'b0;
            end else begin
                state <= F_SECOND;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch) begin
            mop <= macroop_in;
        end
    end

endmodule

// File: logic/rename_decoder.sv
`include "frontend_consts.svh"

module rename_decoder (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`UOP_W-1:0]         microop,
    input  logic                      microop_valid,
    output logic                      microop_ready,
    input  logic [`PR_ADDR_W-1:0]     cmplt_free_reg,
    input  logic                      cmplt_free_valid,
    input  logic [`PR_ADDR_W-1:0]     cmplt_dest_phys,
    input  logic                      cmplt_dest_valid,
    output logic [`RENAMED_OP_SZ-1:0] renamed_op,
    output logic [1:0]                renamed_src_ready,
    output logic                      renamed_valid,
    input  logic                      renamed_ready,
    output logic [`PR_ADDR_W-1:0]     old_alias,
    output logic                      old_alias_valid
);
    import frontend_pkg::*;

    logic [`PR_ADDR_W-1:0] map_table [`ARCH_REGS];
    logic [`PR_ADDR_W-1:0] fl_mem [`PHYS_REGS];
    logic [`PR_ADDR_W-1:0] fl_rd;
    logic [`PR_ADDR_W-1:0] fl_wr;
    logic [`PR_ADDR_W:0]   fl_count;
    logic [`PHYS_REGS-1:0] done_sb;

    uop_op_e               u_op;
    logic [`AR_ADDR_W-1:0] u_dst;
    logic [`AR_ADDR_W-1:0] u_s1;
    logic [`AR_ADDR_W-1:0] u_s2;
    logic                  needs_dest;
    logic                  take;
    logic                  alloc;
    logic [`PR_ADDR_W-1:0] p_dst;
    logic [`PR_ADDR_W-1:0] p_s1;
    logic [`PR_ADDR_W-1:0] p_s2;
    logic                  s1_rdy;
    logic                  s2_rdy;
    logic [`PR_ADDR_W-1:0] out_s1;
    logic [`PR_ADDR_W-1:0] out_s2;

    assign u_op  = uop_op_e'(microop[`UOP_W-1 -: `OPC_W]);
    assign u_dst = microop[3*`AR_ADDR_W-1 -: `AR_ADDR_W];
    assign u_s1  = microop[2*`AR_ADDR_W-1 -: `AR_ADDR_W];
    assign u_s2  = microop[`AR_ADDR_W-1:0];

    assign needs_dest = (u_op == U_ADD) | (u_op == U_SUB) | (u_op == U_AND) | (u_op == U_LOAD);

    // a destination can only be renamed while the free list holds a register.
    assign microop_ready = (~renamed_valid | renamed_ready) & (~needs_dest | (fl_count != '0));
    assign take  = microop_valid & microop_ready;
    assign alloc = take & needs_dest;

    assign p_dst = needs_dest ? fl_mem[fl_rd] : '0;
    assign p_s1  = map_table[u_s1];
    assign p_s2  = map_table[u_s2];

    // a completion landing in the capture cycle already counts.
    assign s1_rdy = done_sb[p_s1] | (cmplt_dest_valid & (cmplt_dest_phys == p_s1));
    assign s2_rdy = done_sb[p_s2] | (cmplt_dest_valid & (cmplt_dest_phys == p_s2));

    assign out_s1 = renamed_op[2*`PR_ADDR_W-1 -: `PR_ADDR_W];
    assign out_s2 = renamed_op[`PR_ADDR_W-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map_table[i] <= `PR_ADDR_W'(i);
            end
            for (int i = 0; i < `PHYS_REGS; i++) begin
                fl_mem[i] <= `PR_ADDR_W'(i + `ARCH_REGS);
            end
            fl_rd           <= '0;
            fl_wr           <= `PR_ADDR_W'(`PHYS_REGS - `ARCH_REGS);
            fl_count        <= (`PR_ADDR_W + 1)'(`PHYS_REGS - `ARCH_REGS);
            done_sb         <= `PHYS_REGS'((1 << `ARCH_REGS) - 1);
            renamed_valid   <= 1'b0;
            old_alias_valid <= 1'b0;
        end else begin
            if (cmplt_free_valid) begin
                fl_mem[fl_wr] <= cmplt_free_reg;
                fl_wr         <= fl_wr + 1'b1;
            end
            if (alloc) begin
                fl_rd              <= fl_rd + 1'b1;
                map_table[u_dst]   <= p_dst;
            end
            fl_count <= fl_count + cmplt_free_valid - alloc;
            if (cmplt_dest_valid) begin
                done_sb[cmplt_dest_phys] <= 1'b1;
            end
            if (alloc) begin
                done_sb[p_dst] <= 1'b0;
            end
            if (take) begin
                renamed_valid <= 1'b1;
            end else if (renamed_ready) begin
                renamed_valid <= 1'b0;
            end
            old_alias_valid <= alloc;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            renamed_op        <= {u_op, p_dst, p_s1, p_s2};
            renamed_src_ready <= {s1_rdy, s2_rdy};
        end else begin
            // keep the held operation current while it waits downstream.
            if (cmplt_dest_valid && (cmplt_dest_phys == out_s1)) begin
                renamed_src_ready[1] <= 1'b1;
            end
            if (cmplt_dest_valid && (cmplt_dest_phys == out_s2)) begin
                renamed_src_ready[0] <= 1'b1;
            end
        end
        if (alloc) begin
            old_alias <= map_table[u_dst];
        end
    end

endmodule

// File: logic/type_sort.sv
`include "frontend_consts.svh"

module type_sort (
    input  logic [`RENAMED_OP_SZ-1:0] renamed_op,
    input  logic                      renamed_valid,
    output logic                      renamed_ready,
    input  logic [1:0]                renamed_src_ready,
    output logic [`RENAMED_OP_SZ-1:0] alu_op,
    output logic                      alu_valid,
    input  logic                      alu_ready,
    output logic [1:0]                alu_srcs,
    output logic [`RENAMED_OP_SZ-1:0] mem_op,
    output logic                      mem_valid,
    input  logic                      mem_ready,
    output logic [`RENAMED_OP_SZ-1:0] term_op,
    output logic                      term_valid,
    input  logic                      term_ready
);
    import frontend_pkg::*;

    uop_op_e    op;
    uop_class_e cls;

    assign op = uop_op_e'(renamed_op[`RENAMED_OP_SZ-1 -: `OPC_W]);

    always_comb begin
        unique case (op)
            U_ADD, U_SUB, U_AND: cls = CLS_ALU;
            U_LOAD, U_STORE:     cls = CLS_MEM;
            default:             cls = CLS_TERM; // unused code 5 falls here too.
        endcase
    end

    assign alu_op   = renamed_op;
    assign mem_op   = renamed_op;
    assign term_op  = renamed_op;
    assign alu_srcs = renamed_src_ready;

    assign alu_valid  = renamed_valid & (cls == CLS_ALU);
    assign mem_valid  = renamed_valid & (cls == CLS_MEM);
    assign term_valid = renamed_valid & (cls == CLS_TERM);

    always_comb begin
        unique case (cls)
            CLS_ALU: renamed_ready = alu_ready;
            CLS_MEM: renamed_ready = mem_ready;
            default: renamed_ready = term_ready;
        endcase
    end

endmodule

// File: logic/issue_buffer_ooo.sv
`include "frontend_consts.svh"

module issue_buffer_ooo (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`RENAMED_OP_SZ-1:0] din,
    input  logic [1:0]                din_srcs,
    input  logic                      din_valid,
    output logic                      din_ready,
    input  logic [`PR_ADDR_W-1:0]     cmplt_dest_phys,
    input  logic                      cmplt_dest_valid,
    output logic [`RENAMED_OP_SZ-1:0] dout,
    output logic                      dout_valid,
    input  logic                      dout_ready
);

    logic [`RENAMED_OP_SZ-1:0] slot_op [`ALU_BUF_ELEMS];
    logic [`ALU_BUF_ELEMS-1:0] slot_valid;
    logic [`ALU_BUF_ELEMS-1:0] s1_done;
    logic [`ALU_BUF_ELEMS-1:0] s2_done;
    logic [`ALU_BUF_IDX_W-1:0] issue_idx;
    logic [`ALU_BUF_IDX_W-1:0] free_idx;
    logic                      issue_hit;
    logic                      din_s1_hit;
    logic                      din_s2_hit;

    // both loops run downwards so the lowest index wins.
    always_comb begin
        issue_hit = 1'b0;
        issue_idx = '0;
        free_idx  = '0;
        for (int i = `ALU_BUF_ELEMS - 1; i >= 0; i--) begin
            if (slot_valid[i] && s1_done[i] && s2_done[i]) begin
                issue_hit = 1'b1;
                issue_idx = `ALU_BUF_IDX_W'(i);
            end
            if (!slot_valid[i]) begin
                free_idx = `ALU_BUF_IDX_W'(i);
            end
        end
    end

    assign din_ready  = ~&slot_valid;
    assign dout       = slot_op[issue_idx];
    assign dout_valid = issue_hit;

    assign din_s1_hit = cmplt_dest_valid & (cmplt_dest_phys == din[2*`PR_ADDR_W-1 -: `PR_ADDR_W]);
    assign din_s2_hit = cmplt_dest_valid & (cmplt_dest_phys == din[`PR_ADDR_W-1:0]);

    always_ff @(posedge clk) begin
        if (rst) begin
            slot_valid <= '0;
        end else begin
            for (int i = 0; i < `ALU_BUF_ELEMS; i++) begin
                if (cmplt_dest_valid
                        && (cmplt_dest_phys == slot_op[i][2*`PR_ADDR_W-1 -: `PR_ADDR_W])) begin
                    s1_done[i] <= 1'b1;
                end
                if (cmplt_dest_valid && (cmplt_dest_phys == slot_op[i][`PR_ADDR_W-1:0])) begin
                    s2_done[i] <= 1'b1;
                end
            end
            if (dout_valid && dout_ready) begin
                slot_valid[issue_idx] <= 1'b0;
            end
            if (din_valid && din_ready) begin
                slot_valid[free_idx] <= 1'b1;
                slot_op[free_idx]    <= din;
                s1_done[free_idx]    <= din_srcs[1] | din_s1_hit;
                s2_done[free_idx]    <= din_srcs[0] | din_s2_hit;
            end
        end
    end

endmodule

// File: logic/frontend.sv
`include "frontend_consts.svh"

module frontend (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wakeup,
    input  logic [`MACRO_OP_W-1:0]    instr,
    input  logic                      instr_valid,
    output logic                      instr_ready,
    input  logic [`PR_ADDR_W-1:0]     cmplt_dest_phys,
    input  logic                      cmplt_dest_valid,
    input  logic [`PR_ADDR_W-1:0]     cmplt_free_reg,
    input  logic                      cmplt_free_valid,
    output logic [`PR_ADDR_W-1:0]     old_alias,
    output logic                      old_alias_valid,
    output logic [`RENAMED_OP_SZ-1:0] alu_op,
    output logic                      alu_op_valid,
    input  logic                      alu_op_ready,
    output logic [`RENAMED_OP_SZ-1:0] mem_op,
    output logic                      mem_op_valid,
    input  logic                      mem_op_ready,
    output logic [`RENAMED_OP_SZ-1:0] term_op,
    output logic                      term_op_valid,
    input  logic                      term_op_ready
);

    logic [`UOP_W-1:0]         microop;
    logic                      microop_valid;
    logic                      microop_ready;
    logic [`RENAMED_OP_SZ-1:0] renamed_op;
    logic [1:0]                renamed_src_ready;
    logic                      renamed_valid;
    logic                      renamed_ready;
    logic [`RENAMED_OP_SZ-1:0] sort_alu_op;
    logic [1:0]                sort_alu_srcs;
    logic                      sort_alu_valid;
    logic                      sort_alu_ready;
    logic                      running;
    logic                      do_microops;

    // a terminator leaving stops the flow into rename until woken.
    assign do_microops = (running & ~(term_op_valid & term_op_ready)) | wakeup;

    uop_fetch u_fetch (
        .clk            (clk),
        .rst            (rst),
        .fetch          (instr_valid & instr_ready),
        .macroop_in     (instr),
        .microops_ready (microop_ready & do_microops),
        .microop        (microop),
        .microop_valid  (microop_valid),
        .instr_ready    (instr_ready)
    );

    rename_decoder u_rename (
        .clk               (clk),
        .rst               (rst),
        .microop           (microop),
        .microop_valid     (microop_valid & do_microops),
        .microop_ready     (microop_ready),
        .cmplt_free_reg    (cmplt_free_reg),
        .cmplt_free_valid  (cmplt_free_valid),
        .cmplt_dest_phys   (cmplt_dest_phys),
        .cmplt_dest_valid  (cmplt_dest_valid),
        .renamed_op        (renamed_op),
        .renamed_src_ready (renamed_src_ready),
        .renamed_valid     (renamed_valid),
        .renamed_ready     (renamed_ready),
        .old_alias         (old_alias),
        .old_alias_valid   (old_alias_valid)
    );

    type_sort u_sort (
        .renamed_op        (renamed_op),
        .renamed_valid     (renamed_valid),
        .renamed_ready     (renamed_ready),
        .renamed_src_ready (renamed_src_ready),
        .alu_op            (sort_alu_op),
        .alu_valid         (sort_alu_valid),
        .alu_ready         (sort_alu_ready),
        .alu_srcs          (sort_alu_srcs),
        .mem_op            (mem_op),
        .mem_valid         (mem_op_valid),
        .mem_ready         (mem_op_ready),
        .term_op           (term_op),
        .term_valid        (term_op_valid),
        .term_ready        (term_op_ready)
    );

    issue_buffer_ooo u_alu_buf (
        .clk              (clk),
        .rst              (rst),
        .din              (sort_alu_op),
        .din_srcs         (sort_alu_srcs),
        .din_valid        (sort_alu_valid),
        .din_ready        (sort_alu_ready),
        .cmplt_dest_phys  (cmplt_dest_phys),
        .cmplt_dest_valid (cmplt_dest_valid),
        .dout             (alu_op),
        .dout_valid       (alu_op_valid),
        .dout_ready       (alu_op_ready)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b1;
        end else begin
            running <= do_microops;
        end
    end

endmodule

// File: test/frontend_chk.sv
`include "frontend_consts.svh"

module frontend_chk (
    input logic                      clk,
    input logic                      rst,
    input logic [`RENAMED_OP_SZ-1:0] mem_op,
    input logic                      mem_op_valid,
    input logic                      mem_op_ready,
    input logic [`RENAMED_OP_SZ-1:0] term_op,
    input logic                      term_op_valid,
    input logic                      term_op_ready,
    input logic                      alu_op_valid,
    input logic [`PR_ADDR_W-1:0]     old_alias,
    input logic                      old_alias_valid
);

    int fail_count = 0;

    mem_held: assert property (@(posedge clk) disable iff (rst)
        mem_op_valid && !mem_op_ready |=> mem_op_valid && $stable(mem_op))
        else begin
            $error("mem_op changed while stalled");
            fail_count++;
        end

    term_held: assert property (@(posedge clk) disable iff (rst)
        term_op_valid && !term_op_ready |=> term_op_valid && $stable(term_op))
        else begin
            $error("term_op changed while stalled");
            fail_count++;
        end

    quiet_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !mem_op_valid && !term_op_valid && !alu_op_valid && !old_alias_valid)
        else begin
            $error("valid output high right after reset");
            fail_count++;
        end

    // back-to-back renames always name different old registers.
    alias_pulse: assert property (@(posedge clk) disable iff (rst)
        old_alias_valid |=> !old_alias_valid || (old_alias != $past(old_alias)))
        else begin
            $error("old_alias repeated on back-to-back renames");
            fail_count++;
        end

endmodule

// File: test/frontend_tb.sv
`include "frontend_consts.svh"

module frontend_tb;
    import frontend_pkg::*;

    localparam int N_MACRO    = 200;
    localparam int MAX_CYCLES = N_MACRO * 40;

    logic clk, rst, wakeup, instr_valid, instr_ready;
    logic [7:0] instr;
    logic [2:0] cmplt_dest_phys, cmplt_free_reg, old_alias;
    logic cmplt_dest_valid, cmplt_free_valid, old_alias_valid;
    logic [11:0] alu_op, mem_op, term_op;
    logic alu_op_valid, alu_op_ready, mem_op_valid, mem_op_ready;
    logic term_op_valid, term_op_ready;

    logic [31:0] lfsr;
    int cyc, sent, next_id, drv_done_id, wake_at, n_checks;
    bit instr_taken, waiting;
    int map_phys [4];
    int map_prod [4];
    bit done_ids [0:4095];
    int fl_q[$];
    logic [8:0] uq[$];
    logic [11:0] ord_word[$], alu_word[$];
    int ord_id[$], alu_id[$], alu_p1[$], alu_p2[$];
    int oa_phys[$], oa_prod[$];
    int fq_phys[$], fq_prod[$], fq_due[$];
    int cq_phys[$], cq_id[$], cq_due[$];
    int exp_cnt [3];
    int got_cnt [3];
    int errs [5];
    string test_names [5] = '{"program order", "renaming", "alu issue", "totals", "wakeup"};

    frontend UUT (.*);

    bind frontend frontend_chk u_chk (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(MAX_CYCLES * 8);
        $display("watchdog expired before all operations came out");
        $display("TESTS FAILED");
        $finish;
    end

    // a Galois LFSR that steps once for each bit taken.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic int class_of(input logic [2:0] op);
        if (op == U_ADD || op == U_SUB || op == U_AND) return int'(CLS_ALU);
        if (op == U_LOAD || op == U_STORE) return int'(CLS_MEM);
        return int'(CLS_TERM);
    endfunction

    task automatic report(input int t, input string sig, input logic [11:0] got,
                          input logic [11:0] exp);
        errs[t]++;
        $display("** Error at %0t: %s = %h, expected %h", $time, sig, got, exp);
    endtask

    task automatic add_uop(input uop_op_e op, input logic [1:0] d, s1, s2);
        uq.push_back({op, d, s1, s2});
        exp_cnt[class_of(op)]++;
    endtask

    task automatic expand(input logic [7:0] m);
        logic [1:0] d;
        logic [1:0] s;
        d = m[4:3];
        s = m[2:1];
        case (macro_op_e'(m[7:5]))
            M_ADD:    add_uop(U_ADD, d, d, s);
            M_SUB:    add_uop(U_SUB, d, d, s);
            M_AND:    add_uop(U_AND, d, d, s);
            M_LOAD:   add_uop(U_LOAD, d, s, s);
            M_STORE:  add_uop(U_STORE, 2'd0, d, s);
            M_LDADD: begin
                add_uop(U_LOAD, d, s, s);
                add_uop(U_ADD, d, d, d);
            end
            M_BRANCH: add_uop(U_BRANCH, 2'd0, s, s);
            default:  add_uop(U_HALT, 2'd0, s, s);
        endcase
    endtask

    // renames the next micro-op of the model in program order.
    task automatic rename_next(output bit ok);
        logic [8:0] u;
        int d, s1, s2, pd, id;
        logic [11:0] w;
        bit wr;
        ok = 1'b0;
        if (uq.size() == 0) return;
        u = uq.pop_front();
        d = u[5:4];
        s1 = u[3:2];
        s2 = u[1:0];
        id = next_id++;
        pd = 0;
        wr = (class_of(u[8:6]) == int'(CLS_ALU)) || (u[8:6] == U_LOAD);
        w = {u[8:6], 3'd0, 3'(map_phys[s1]), 3'(map_phys[s2])};
        if (wr) begin
            if (fl_q.size() == 0) begin
                $display("model free list empty while renaming operation %0d", id);
                errs[1]++;
                return;
            end
            pd = fl_q.pop_front();
            w[8:6] = 3'(pd);
            oa_phys.push_back(map_phys[d]);
            oa_prod.push_back(map_prod[d]);
        end
        if (class_of(u[8:6]) == int'(CLS_ALU)) begin
            alu_word.push_back(w);
            alu_id.push_back(id);
            alu_p1.push_back(map_prod[s1]);
            alu_p2.push_back(map_prod[s2]);
        end else begin
            ord_word.push_back(w);
            ord_id.push_back(id);
        end
        if (wr) begin
            map_phys[d] = pd;
            map_prod[d] = id;
        end
        ok = 1'b1;
    endtask

    task automatic check_ordered(input logic [11:0] w, input int cls, input string sig);
        bit ok;
        logic [11:0] exp_w;
        ok = 1'b1;
        while (ord_word.size() == 0 && ok) rename_next(ok);
        n_checks++;
        if (ord_word.size() == 0) begin
            $display("%s transferred with no operation expected at %0t", sig, $time);
            errs[0]++;
            return;
        end
        exp_w = ord_word[0];
        if (w != exp_w || class_of(w[11:9]) != cls) report(0, sig, w, exp_w);
        got_cnt[cls]++;
        if (exp_w[11:9] == U_LOAD) begin
            cq_phys.push_back(int'(exp_w[8:6]));
            cq_id.push_back(ord_id[0]);
            cq_due.push_back(cyc + 1 + int'(rand_bits(3)));
        end
        void'(ord_word.pop_front());
        void'(ord_id.pop_front());
    endtask

    task automatic check_alu(input logic [11:0] w);
        bit ok;
        int hit;
        ok = 1'b1;
        hit = -1;
        n_checks++;
        while (hit < 0) begin
            foreach (alu_word[i]) begin
                if (hit < 0 && alu_word[i] == w && (alu_p1[i] < 0 || done_ids[alu_p1[i]])
                        && (alu_p2[i] < 0 || done_ids[alu_p2[i]])) hit = i;
            end
            if (hit >= 0 || !ok) break;
            rename_next(ok);
        end
        if (hit < 0) begin
            $display("alu_op %h issued with no matching ready operation at %0t", w, $time);
            errs[2]++;
            return;
        end
        got_cnt[CLS_ALU]++;
        cq_phys.push_back(int'(w[8:6]));
        cq_id.push_back(alu_id[hit]);
        cq_due.push_back(cyc + 1 + int'(rand_bits(3)));
        alu_word.delete(hit);
        alu_id.delete(hit);
        alu_p1.delete(hit);
        alu_p2.delete(hit);
    endtask

    task automatic drive_inputs();
        int k;
        if (instr_taken) instr_valid = 1'b0;
        if (!instr_valid && sent < N_MACRO && rand_bits(2) != 0) begin
            instr = 8'(rand_bits(8));
            instr_valid = 1'b1;
        end
        alu_op_ready = (rand_bits(2) != 0);
        mem_op_ready = (rand_bits(2) != 0);
        term_op_ready = (rand_bits(2) != 0);
        wakeup = 1'b0;
        if (waiting && cyc >= wake_at) begin
            wakeup = 1'b1;
            waiting = 1'b0;
        end
        cmplt_dest_valid = 1'b0;
        k = -1;
        foreach (cq_due[i]) if (k < 0 && cq_due[i] <= cyc) k = i;
        if (k >= 0) begin
            cmplt_dest_valid = 1'b1;
            cmplt_dest_phys = 3'(cq_phys[k]);
            drv_done_id = cq_id[k];
            cq_phys.delete(k);
            cq_id.delete(k);
            cq_due.delete(k);
        end
        // a register goes back only once its producer has completed.
        cmplt_free_valid = 1'b0;
        if (fq_phys.size() > 0 && fq_due[0] <= cyc
                && (fq_prod[0] < 0 || done_ids[fq_prod[0]])) begin
            cmplt_free_valid = 1'b1;
            cmplt_free_reg = 3'(fq_phys[0]);
            fl_q.push_back(fq_phys.pop_front());
            void'(fq_prod.pop_front());
            void'(fq_due.pop_front());
        end
    endtask

    task automatic check_outputs();
        bit ok;
        instr_taken = instr_valid && instr_ready;
        if (instr_taken) begin
            expand(instr);
            sent++;
        end
        if (waiting && (mem_op_valid || term_op_valid || old_alias_valid)) begin
            $display("operation moved at %0t before wakeup after a terminator", $time);
            errs[4]++;
        end
        if (old_alias_valid) begin
            ok = 1'b1;
            while (oa_phys.size() == 0 && ok) rename_next(ok);
            n_checks++;
            if (oa_phys.size() == 0) begin
                $display("old_alias pulse at %0t with no rename expected", $time);
                errs[1]++;
            end else begin
                if (int'(old_alias) != oa_phys[0]) report(1, "old_alias", old_alias, oa_phys[0]);
                fq_phys.push_back(oa_phys[0]);
                fq_prod.push_back(oa_prod[0]);
                fq_due.push_back(cyc + 1 + int'(rand_bits(3)));
                void'(oa_phys.pop_front());
                void'(oa_prod.pop_front());
            end
        end
        if (mem_op_valid && mem_op_ready) check_ordered(mem_op, int'(CLS_MEM), "mem_op");
        if (term_op_valid && term_op_ready) begin
            check_ordered(term_op, int'(CLS_TERM), "term_op");
            waiting = 1'b1;
            wake_at = cyc + 1 + int'(rand_bits(3));
        end
        if (alu_op_valid && alu_op_ready) check_alu(alu_op);
        if (drv_done_id >= 0) done_ids[drv_done_id] = 1'b1;
        drv_done_id = -1;
    endtask

    task automatic one_cycle();
        @(negedge clk);
        cyc++;
        drive_inputs();
        #1;
        check_outputs();
    endtask

    initial begin
        int total;
        lfsr = 32'haccc_ce66;
        rst = 1'b1;
        wakeup = 1'b0;
        instr = '0;
        instr_valid = 1'b0;
        cmplt_dest_phys = '0;
        cmplt_dest_valid = 1'b0;
        cmplt_free_reg = '0;
        cmplt_free_valid = 1'b0;
        alu_op_ready = 1'b0;
        mem_op_ready = 1'b0;
        term_op_ready = 1'b0;
        drv_done_id = -1;
        for (int i = 0; i < 4; i++) begin
            map_phys[i] = i;
            map_prod[i] = -1;
            fl_q.push_back(i + 4);
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        while (sent < N_MACRO || got_cnt[0] + got_cnt[1] + got_cnt[2]
                < exp_cnt[0] + exp_cnt[1] + exp_cnt[2]) one_cycle();
        repeat (20) one_cycle(); // anything extra would be a duplicate.
        for (int c = 0; c < 3; c++) begin
            n_checks++;
            if (got_cnt[c] != exp_cnt[c]) begin
                $display("class %0d gave %0d operations, model expects %0d",
                         c, got_cnt[c], exp_cnt[c]);
                errs[3]++;
            end
        end
        n_checks++;
        if (uq.size() + ord_word.size() + alu_word.size() != 0) begin
            $display("model still holds operations that never came out");
            errs[2]++;
        end
        total = 0;
        for (int t = 0; t < 5; t++) begin
            $display("test %0d %s: %0d errors", t + 1, test_names[t], errs[t]);
            total += errs[t];
        end
        if (UUT.u_chk.fail_count != 0) begin
            $display("checker assertions failed %0d times", UUT.u_chk.fail_count);
            total += UUT.u_chk.fail_count;
        end
        $display("%0d macro-ops, %0d checks, %0d errors", sent, n_checks, total);
        if (total == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: frontend.f
+incdir+include
logic/frontend_pkg.sv
logic/uop_fetch.sv
logic/rename_decoder.sv
logic/type_sort.sv
logic/issue_buffer_ooo.sv
logic/frontend.sv
test/frontend_chk.sv
test/frontend_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= frontend_tb
RTL_TOP   ?= frontend
FLIST     ?= frontend.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
LFLAGS    ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) $(LFLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
